//--- async_fifo.f
+incdir+verilog
verilog/async_fifo_pkg.sv
verilog/gray_ptr_sync.sv
verilog/fifo_wr_port.sv
verilog/fifo_rd_port.sv
verilog/fifo_mem.sv
verilog/fifo_control.sv
verilog/async_fifo.sv
tests/async_fifo_sva.sv
tests/async_fifo_tb.sv

//--- Bender.yml
package:
  name: async_fifo

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/async_fifo_pkg.sv
      - verilog/gray_ptr_sync.sv
      - verilog/fifo_wr_port.sv
      - verilog/fifo_rd_port.sv
      - verilog/fifo_mem.sv
      - verilog/fifo_control.sv
      - verilog/async_fifo.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/async_fifo_sva.sv
      - tests/async_fifo_tb.sv

//--- tests/async_fifo_tb.sv
`timescale 1ns/100ps
`include "async_fifo_macros.svh"

module async_fifo_tb;
        import async_fifo_pkg::*;

        // Fill levels where the almost flags should switch
        localparam int DEPTH    = `FIFO_DEPTH;
        localparam int AF_LEVEL = `FIFO_DEPTH - `FIFO_ALMOST_WR_MARGIN;
        localparam int AE_LEVEL = `FIFO_ALMOST_RD_MARGIN;

        // Conditions for wait_until
        localparam int UNTIL_FULL   = 0;
        localparam int UNTIL_READS  = 1;
        localparam int UNTIL_EMPTY  = 2;
        localparam int UNTIL_WRITES = 3;

        logic  wr_clk = 1'b0;
        logic  rd_clk = 1'b0;
        logic  wr_rst_n;
        logic  rd_rst_n;
        logic  wr_en;
        logic  rd_en;
        data_t wr_data;
        data_t rd_data;
        logic  wr_full;
        logic  wr_almost_full;
        logic  rd_empty;
        logic  rd_almost_empty;
        ptr_t  count;

        // Writer and reader control, 0 idle, 1 spaced strobes, 2 random
        int wr_mode;
        int rd_mode;
        int wr_limit;
        int rd_hold;
        // Accepted words on each side
        int wr_idx;
        int rd_idx;
        int errors;
        int base;
        integer seed = 32'h6fdfb296;
        logic [31:0] wr_rnd;
        logic [31:0] rd_rnd;

        always #7 wr_clk = ~wr_clk;
        always #10 rd_clk = ~rd_clk;

        async_fifo uut (
                .wr_clk          (wr_clk),
                .wr_rst_n        (wr_rst_n),
                .wr_en           (wr_en),
                .wr_data         (wr_data),
                .rd_clk          (rd_clk),
                .rd_rst_n        (rd_rst_n),
                .rd_en           (rd_en),
                .rd_data         (rd_data),
                .wr_full         (wr_full),
                .wr_almost_full  (wr_almost_full),
                .rd_empty        (rd_empty),
                .rd_almost_empty (rd_almost_empty),
                .count           (count)
        );

        // Payload of the n-th accepted word
        function automatic data_t expected_word(input int n);
                return data_t'(n * 40503 + 16'h1d2b) ^ data_t'(n >> 4);
        endfunction

        task automatic check_value(input string name, input logic [31:0] actual,
                                   input logic [31:0] expected);
                if (actual !== expected) begin
                        errors++;
                        $display("ERROR %0t %s: actual %0h, expected %0h",
                                 $time, name, actual, expected);
                end
        endtask

        function automatic bit reached(input int kind, input int target);
                case (kind)
                        UNTIL_FULL:  return wr_full;
                        UNTIL_READS: return rd_idx >= target;
                        UNTIL_EMPTY: return rd_empty;
                        default:     return wr_idx >= target;
                endcase
        endfunction

        // Bounded wait, sampled away from both rising edges
        task automatic wait_until(input int kind, input int target, input string what);
                int cycles;
                cycles = 0;
                while (!reached(kind, target) && cycles < 1000) begin
                        @(negedge rd_clk);
                        cycles++;
                end
                if (!reached(kind, target)) begin
                        errors++;
                        $display("Timeout while waiting for %s at %0t", what, $time);
                end
        endtask

        // Flags settle within four cycles of either clock
        task automatic settle();
                repeat (8) @(negedge rd_clk);
        endtask

        // ------------------------------------------------------------------------
        // Writer
        // ------------------------------------------------------------------------

        always @(posedge wr_clk) begin
                if (wr_en && !wr_full) begin
                        wr_idx = wr_idx + 1;
                end
                if (wr_mode == 1) begin
                        // Idle cycle after each strobe so wr_full is current
                        wr_en <= !wr_en && (wr_idx < wr_limit);
                end else if (wr_mode == 2) begin
                        // Almost-full covers the flag latency
                        wr_rnd = $random(seed);
                        wr_en <= wr_rnd[0] && !wr_almost_full;
                end else begin
                        wr_en <= 1'b0;
                end
                wr_data <= expected_word(wr_idx);
        end

        // ------------------------------------------------------------------------
        // Reader and comparison
        // ------------------------------------------------------------------------

        always @(posedge rd_clk) begin
                if (rd_hold > 0) begin
                        rd_en   <= 1'b0;
                        rd_hold = rd_hold - 1;
                end else if (rd_mode == 1 && !rd_empty) begin
                        // Two idle cycles until rd_empty reflects this read
                        rd_en   <= 1'b1;
                        rd_hold = 2;
                end else if (rd_mode == 2) begin
                        rd_rnd = $random(seed);
                        rd_en <= rd_rnd[0] && !rd_almost_empty;
                end else begin
                        rd_en <= 1'b0;
                end
        end

        always @(posedge rd_clk) begin
                if (rd_en && !rd_empty) begin
                        check_value("rd_data", rd_data, expected_word(rd_idx));
                        rd_idx = rd_idx + 1;
                end
        end

        // ------------------------------------------------------------------------
        // Sequence
        // ------------------------------------------------------------------------

        initial begin
                wr_rst_n = 1'b0;
                rd_rst_n = 1'b0;
                wr_en    = 1'b0;
                rd_en    = 1'b0;
                wr_data  = '0;
                wr_mode  = 0;
                rd_mode  = 0;
                wr_limit = 0;
                repeat (8) @(posedge rd_clk);
                wr_rst_n <= 1'b1;
                rd_rst_n <= 1'b1;
                settle();
                check_value("rd_empty", rd_empty, 1);
                check_value("wr_full", wr_full, 0);
                check_value("count", count, 0);

                // Fill with the reader idle, then keep pushing into a full FIFO
                wr_limit = 1 << 30;
                wr_mode  = 1;
                wait_until(UNTIL_FULL, 0, "wr_full to rise");
                settle();
                wr_mode = 0;
                settle();
                check_value("accepted writes", wr_idx, DEPTH);
                check_value("count", count, DEPTH);
                check_value("wr_almost_full", wr_almost_full, 1);

                // Drain, dropped words must not show up
                rd_mode = 1;
                wait_until(UNTIL_READS, DEPTH, "the first 16 reads");
                wait_until(UNTIL_EMPTY, 0, "rd_empty after the drain");
                settle();
                check_value("words read", rd_idx, DEPTH);
                rd_mode = 0;

                // Almost flags at their exact levels
                base     = wr_idx;
                wr_limit = base + AE_LEVEL;
                wr_mode  = 1;
                wait_until(UNTIL_WRITES, wr_limit, "the almost-empty fill");
                settle();
                check_value("rd_almost_empty", rd_almost_empty, 1);
                wr_limit = base + AF_LEVEL - 1;
                wait_until(UNTIL_WRITES, wr_limit, "one word below almost-full");
                settle();
                check_value("wr_almost_full", wr_almost_full, 0);
                wr_limit = base + AF_LEVEL;
                wait_until(UNTIL_WRITES, wr_limit, "the almost-full fill");
                settle();
                check_value("wr_almost_full", wr_almost_full, 1);
                wr_mode = 0;
                rd_mode = 1;
                wait_until(UNTIL_READS, wr_idx, "the almost-flag drain");
                wait_until(UNTIL_EMPTY, 0, "rd_empty after the almost-flag drain");
                rd_mode = 0;

                // Concurrent random traffic
                wr_limit = 1 << 30;
                wr_mode  = 2;
                rd_mode  = 2;
                repeat (2000) @(negedge rd_clk);
                wr_mode = 0;
                rd_mode = 0;
                settle();
                rd_mode = 1;
                wait_until(UNTIL_READS, wr_idx, "the final drain");
                wait_until(UNTIL_EMPTY, 0, "rd_empty after the final drain");
                settle();
                check_value("words read", rd_idx, wr_idx);

                // Bound assertion failures
                errors = errors + uut.u_sva.fail_count;

                $display("Checks done with %0d errors", errors);
                if (errors == 0) begin
                        $display("** PASS **");
                end else begin
                        $display("** FAIL **");
                end
                $finish;
        end

endmodule : async_fifo_tb

//--- tests/async_fifo_sva.sv
`timescale 1ns/100ps
`include "async_fifo_macros.svh"

module async_fifo_sva
        import async_fifo_pkg::*;
(
        input logic wr_clk,
        input logic wr_rst_n,
        input logic rd_clk,
        input logic rd_rst_n,
        input ptr_t wr_ptr_bin,
        input ptr_t rd_ptr_bin,
        input ptr_t wdom_rd_ptr_bin,
        input ptr_t rdom_wr_ptr_bin,
        input logic wr_full,
        input logic rd_empty,
        input logic rd_almost_empty,
        input ptr_t count
);

        localparam ptr_t AE_LEVEL = ptr_t'(`FIFO_ALMOST_RD_MARGIN);

        // Failed assertion count
        int fail_count = 0;

        // Both crossings caught up
        logic ptrs_agree;
        assign ptrs_agree = (wdom_rd_ptr_bin == rd_ptr_bin) && (rdom_wr_ptr_bin == wr_ptr_bin);

        // --------------------------------------------------------------------------
        // Flag consistency
        // --------------------------------------------------------------------------

        // Two rd_clk cycles cover the flag flops of both sides
        full_and_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n || !wr_rst_n)
                ptrs_agree ##1 ptrs_agree |-> !(rd_empty && wr_full))
                else begin
                        fail_count++;
                        $error("rd_empty and wr_full high together with settled pointers");
                end

        // Flag comes out of reset low
        // Sampled reset skips the release edge
        almost_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
                rd_rst_n && (count <= AE_LEVEL) |=> rd_almost_empty)
                else begin
                        fail_count++;
                        $error("rd_almost_empty low one cycle after a low count");
                end

        // --------------------------------------------------------------------------
        // Pointer gating
        // --------------------------------------------------------------------------

        wr_hold: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
                wr_full |=> $stable(wr_ptr_bin))
                else begin
                        fail_count++;
                        $error("Write pointer moved while full");
                end

        rd_hold: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
                rd_empty |=> $stable(rd_ptr_bin))
                else begin
                        fail_count++;
                        $error("Read pointer moved while empty");
                end

endmodule : async_fifo_sva

bind async_fifo async_fifo_sva u_sva (
        .wr_clk          (wr_clk),
        .wr_rst_n        (wr_rst_n),
        .rd_clk          (rd_clk),
        .rd_rst_n        (rd_rst_n),
        .wr_ptr_bin      (wr_ptr_bin),
        .rd_ptr_bin      (rd_ptr_bin),
        .wdom_rd_ptr_bin (wdom_rd_ptr_bin),
        .rdom_wr_ptr_bin (rdom_wr_ptr_bin),
        .wr_full         (wr_full),
        .rd_empty        (rd_empty),
        .rd_almost_empty (rd_almost_empty),
        .count           (count)
);

//--- verilog/async_fifo.sv
`timescale 1ns/100ps
`include "async_fifo_macros.svh"

module async_fifo
        import async_fifo_pkg::*;
(
        // Write side
        input  logic  wr_clk,
        input  logic  wr_rst_n,
        input  logic  wr_en,
        input  data_t wr_data,
        // Read side
        input  logic  rd_clk,
        input  logic  rd_rst_n,
        input  logic  rd_en,
        output data_t rd_data,
        // Status
        output logic  wr_full,
        output logic  wr_almost_full,
        output logic  rd_empty,
        output logic  rd_almost_empty,
        output ptr_t  count
);

        // Accepted write strobe
        logic wr_inc;
        // Local pointers
        ptr_t wr_ptr_bin;
        ptr_t rd_ptr_bin;
        // Pointers after crossing
        ptr_t wdom_rd_ptr_bin;
        ptr_t rdom_wr_ptr_bin;

        // ---------------------------------------------------------------------------
        // Pointer owners
        // ---------------------------------------------------------------------------

        fifo_wr_port u_wr_port (
                .wr_clk     (wr_clk),
                .wr_rst_n   (wr_rst_n),
                .wr_en      (wr_en),
                .wr_full    (wr_full),
                .wr_inc     (wr_inc),
                .wr_ptr_bin (wr_ptr_bin)
        );

        fifo_rd_port u_rd_port (
                .rd_clk     (rd_clk),
                .rd_rst_n   (rd_rst_n),
                .rd_en      (rd_en),
                .rd_empty   (rd_empty),
                .rd_ptr_bin (rd_ptr_bin)
        );

        // ---------------------------------------------------------------------------
        // Storage, indexed by low pointer bits
        // ---------------------------------------------------------------------------

        fifo_mem u_mem (
                .wr_clk  (wr_clk),
                .wr_inc  (wr_inc),
                .wr_addr (wr_ptr_bin[`FIFO_ADDR_WIDTH-1:0]),
                .wr_data (wr_data),
                .rd_addr (rd_ptr_bin[`FIFO_ADDR_WIDTH-1:0]),
                .rd_data (rd_data)
        );

        // ---------------------------------------------------------------------------
        // Clock domain crossings
        // ---------------------------------------------------------------------------

        // Write pointer into rd_clk
        gray_ptr_sync wr_to_rd (
                .src_clk     (wr_clk),
                .src_rst_n   (wr_rst_n),
                .src_ptr_bin (wr_ptr_bin),
                .dst_clk     (rd_clk),
                .dst_rst_n   (rd_rst_n),
                .dst_ptr_bin (rdom_wr_ptr_bin)
        );

        // Read pointer into wr_clk
        gray_ptr_sync rd_to_wr (
                .src_clk     (rd_clk),
                .src_rst_n   (rd_rst_n),
                .src_ptr_bin (rd_ptr_bin),
                .dst_clk     (wr_clk),
                .dst_rst_n   (wr_rst_n),
                .dst_ptr_bin (wdom_rd_ptr_bin)
        );

        // ---------------------------------------------------------------------------
        // Flags and fill level
        // ---------------------------------------------------------------------------

        fifo_control u_control (
                .wr_clk          (wr_clk),
                .wr_rst_n        (wr_rst_n),
                .rd_clk          (rd_clk),
                .rd_rst_n        (rd_rst_n),
                .wr_ptr_bin      (wr_ptr_bin),
                .wdom_rd_ptr_bin (wdom_rd_ptr_bin),
                .rd_ptr_bin      (rd_ptr_bin),
                .rdom_wr_ptr_bin (rdom_wr_ptr_bin),
                .count           (count),
                .wr_full         (wr_full),
                .wr_almost_full  (wr_almost_full),
                .rd_empty        (rd_empty),
                .rd_almost_empty (rd_almost_empty)
        );

endmodule : async_fifo

//--- verilog/fifo_control.sv
`timescale 1ns/100ps
`include "async_fifo_macros.svh"

module fifo_control
        import async_fifo_pkg::*;
(
        // Clocks and resets
        input  logic wr_clk,
        input  logic wr_rst_n,
        input  logic rd_clk,
        input  logic rd_rst_n,
        // Write domain pointers
        input  ptr_t wr_ptr_bin,
        input  ptr_t wdom_rd_ptr_bin,
        // Read domain pointers
        input  ptr_t rd_ptr_bin,
        input  ptr_t rdom_wr_ptr_bin,
        // Status
        output ptr_t count,
        output logic wr_full,
        output logic wr_almost_full,
        output logic rd_empty,
        output logic rd_almost_empty
);

        // Wrap bit position
        localparam int AW = `FIFO_ADDR_WIDTH;

        // Depth as a pointer-wide value, needs the extra bit
        localparam ptr_t DEPTH_P = ptr_t'(`FIFO_DEPTH);
        // Almost-full threshold
        localparam ptr_t AFT = ptr_t'(`FIFO_DEPTH - `FIFO_ALMOST_WR_MARGIN);
        // Almost-empty threshold
        localparam ptr_t AET = ptr_t'(`FIFO_ALMOST_RD_MARGIN);

        // Wrap bits differ
        logic wdom_wrap_diff;
        logic rdom_wrap_diff;
        // Low address bits
        addr_t wdom_wr_addr;
        addr_t wdom_rd_addr;
        addr_t rdom_wr_addr;
        addr_t rdom_rd_addr;
        // Used entries seen by each side
        ptr_t wr_used;
        ptr_t rd_used;
        // Next flag values
        logic wr_full_d;
        logic wr_almost_full_d;
        logic rd_empty_d;
        logic rd_almost_empty_d;

        // ---------------------------------------------------------------------------
        // Write domain
        // ---------------------------------------------------------------------------

        assign wdom_wrap_diff = wr_ptr_bin[AW] ^ wdom_rd_ptr_bin[AW];
        assign wdom_wr_addr   = wr_ptr_bin[AW-1:0];
        assign wdom_rd_addr   = wdom_rd_ptr_bin[AW-1:0];

        // Full when one lap ahead on the same slot
        assign wr_full_d = wdom_wrap_diff && (wdom_wr_addr == wdom_rd_addr);

        // Add a lap when the writer has wrapped past the reader
        assign wr_used = wdom_wrap_diff ?
                         (DEPTH_P + ptr_t'(wdom_wr_addr) - ptr_t'(wdom_rd_addr)) :
                         (ptr_t'(wdom_wr_addr) - ptr_t'(wdom_rd_addr));

        assign wr_almost_full_d = wr_used >= AFT;

        // Stale read pointer only makes these flags pessimistic
        always_ff @(posedge wr_clk or negedge wr_rst_n) begin
                if (!wr_rst_n) begin
                        wr_full        <= 1'b0;
                        wr_almost_full <= 1'b0;
                end else begin
                        wr_full        <= wr_full_d;
                        wr_almost_full <= wr_almost_full_d;
                end
        end

        // ---------------------------------------------------------------------------
        // Read domain
        // ---------------------------------------------------------------------------

        assign rdom_wrap_diff = rd_ptr_bin[AW] ^ rdom_wr_ptr_bin[AW];
        assign rdom_wr_addr   = rdom_wr_ptr_bin[AW-1:0];
        assign rdom_rd_addr   = rd_ptr_bin[AW-1:0];

        // Empty when same lap and same slot
        assign rd_empty_d = !rdom_wrap_diff && (rdom_wr_addr == rdom_rd_addr);

        // Same lap correction as the write side
        assign rd_used = rdom_wrap_diff ?
                         (DEPTH_P + ptr_t'(rdom_wr_addr) - ptr_t'(rdom_rd_addr)) :
                         (ptr_t'(rdom_wr_addr) - ptr_t'(rdom_rd_addr));

        assign rd_almost_empty_d = rd_used <= AET;

        // Unregistered fill level
        assign count = rd_used;

        // Stale write pointer only makes these flags pessimistic
        always_ff @(posedge rd_clk or negedge rd_rst_n) begin
                if (!rd_rst_n) begin
                        rd_empty        <= 1'b1;
                        rd_almost_empty <= 1'b0;
                end else begin
                        rd_empty        <= rd_empty_d;
                        rd_almost_empty <= rd_almost_empty_d;
                end
        end

endmodule : fifo_control

//--- verilog/fifo_mem.sv
`timescale 1ns/100ps
`include "async_fifo_macros.svh"

module fifo_mem
        import async_fifo_pkg::*;
(
        // Write port
        input  logic  wr_clk,
        input  logic  wr_inc,
        input  addr_t wr_addr,
        input  data_t wr_data,
        // Asynchronous read port
        input  addr_t rd_addr,
        output data_t rd_data
);

        // Storage array
        data_t mem [`FIFO_DEPTH];

        // ---------------------------------------------------------------------------
        // Write side
        // ---------------------------------------------------------------------------

        // Stored at the accepting edge
        always_ff @(posedge wr_clk) begin
                if (wr_inc) begin
                        mem[wr_addr] <= wr_data;
                end
        end

        // ---------------------------------------------------------------------------
        // Read side
        // ---------------------------------------------------------------------------

        // Head word, valid while not empty
        // The slot cannot be overwritten until the read pointer has moved on
        assign rd_data = mem[rd_addr];

endmodule : fifo_mem

//--- verilog/fifo_rd_port.sv
`timescale 1ns/100ps

module fifo_rd_port
        import async_fifo_pkg::*;
(
        // Read clock domain
        input  logic rd_clk,
        input  logic rd_rst_n,
        // Strobe from the reader
        input  logic rd_en,
        // Registered empty flag
        input  logic rd_empty,
        // Binary read pointer with wrap bit
        output ptr_t rd_ptr_bin
);

        // Consume strobe
        logic rd_inc;

        // ---------------------------------------------------------------------------
        // Accept decision
        // ---------------------------------------------------------------------------

        // Read while empty is ignored
        assign rd_inc = rd_en && !rd_empty;

        // ---------------------------------------------------------------------------
        // Pointer register
        // ---------------------------------------------------------------------------

        // Next word shows up on rd_data right after this edge
        always_ff @(posedge rd_clk or negedge rd_rst_n) begin
                if (!rd_rst_n) begin
                        rd_ptr_bin <= '0;
                end else if (rd_inc) begin
                        // Full pointer incremented, wrap bit included
                        rd_ptr_bin <= rd_ptr_bin + ptr_t'(1);
                end
        end

endmodule : fifo_rd_port

//--- verilog/fifo_wr_port.sv
`timescale 1ns/100ps

module fifo_wr_port
        import async_fifo_pkg::*;
(
        // Write clock domain
        input  logic wr_clk,
        input  logic wr_rst_n,
        // Strobe from the writer
        input  logic wr_en,
        // Registered full flag
        input  logic wr_full,
        // Memory write enable
        output logic wr_inc,
        // Binary write pointer with wrap bit
        output ptr_t wr_ptr_bin
);

        // ---------------------------------------------------------------------------
        // Accept decision
        // ---------------------------------------------------------------------------

        // Write while full is dropped
        assign wr_inc = wr_en && !wr_full;

        // ---------------------------------------------------------------------------
        // Pointer register
        // ---------------------------------------------------------------------------

        // Advances on the same edge the word is stored
        // Wrap bit flips every DEPTH writes
        always_ff @(posedge wr_clk or negedge wr_rst_n) begin
                if (!wr_rst_n) begin
                        wr_ptr_bin <= '0;
                end else if (wr_inc) begin
                        wr_ptr_bin <= wr_ptr_bin + ptr_t'(1);
                end
        end

endmodule : fifo_wr_port

//--- verilog/gray_ptr_sync.sv
`timescale 1ns/100ps

module gray_ptr_sync
        import async_fifo_pkg::*;
(
        // Source side
        input  logic src_clk,
        input  logic src_rst_n,
        input  ptr_t src_ptr_bin,
        // Destination side
        input  logic dst_clk,
        input  logic dst_rst_n,
        output ptr_t dst_ptr_bin
);

        // Gray register in source domain
        ptr_t src_gray;
        // Two-flop synchronizer chain
        ptr_t sync_meta;
        ptr_t sync_gray;

        // Gray back to binary, MSB first
        function automatic ptr_t gray_to_bin(input ptr_t gray);
                ptr_t bin;
                bin[$bits(ptr_t)-1] = gray[$bits(ptr_t)-1];
                for (int i = $bits(ptr_t) - 2; i >= 0; i--) begin
                        // Each bit folds in everything above it
                        bin[i] = bin[i+1] ^ gray[i];
                end
                return bin;
        endfunction

        // ---------------------------------------------------------------------------
        // Source domain
        // ---------------------------------------------------------------------------

        // Registered so only one bit toggles per pointer step
        always_ff @(posedge src_clk or negedge src_rst_n) begin
                if (!src_rst_n) begin
                        src_gray <= '0;
                end else begin
                        src_gray <= src_ptr_bin ^ (src_ptr_bin >> 1);
                end
        end

        // ---------------------------------------------------------------------------
        // Destination domain
        // ---------------------------------------------------------------------------

        // First stage may go metastable
        always_ff @(posedge dst_clk or negedge dst_rst_n) begin
                if (!dst_rst_n) begin
                        sync_meta <= '0;
                        sync_gray <= '0;
                end else begin
                        sync_meta <= src_gray;
                        sync_gray <= sync_meta;
                end
        end

        // Settled value back in binary
        assign dst_ptr_bin = gray_to_bin(sync_gray);

endmodule : gray_ptr_sync

//--- verilog/async_fifo_pkg.sv
`include "async_fifo_macros.svh"

package async_fifo_pkg;

        // -------------------------------------------------------------------
        // Shared types of the dual-clock FIFO
        // -------------------------------------------------------------------

        // Index into the storage array
        typedef logic [`FIFO_ADDR_WIDTH-1:0] addr_t;

        // Binary pointer plus wrap bit
        // Gray form travels in the same type
        typedef logic [`FIFO_ADDR_WIDTH:0] ptr_t;

        // One payload word
        typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;

endpackage : async_fifo_pkg

//--- verilog/async_fifo_macros.svh
`ifndef ASYNC_FIFO_MACROS_SVH
`define ASYNC_FIFO_MACROS_SVH

// ---------------------------------------------------------------------------
// Geometry
// ---------------------------------------------------------------------------

// Address bits of the storage array
`define FIFO_ADDR_WIDTH 4

// Entry count, always a power of two
`define FIFO_DEPTH (1 << `FIFO_ADDR_WIDTH)

// Payload width in bits
`define FIFO_DATA_WIDTH 16

// ---------------------------------------------------------------------------
// Early warning thresholds
// ---------------------------------------------------------------------------

// Almost-full once used >= depth - margin
`define FIFO_ALMOST_WR_MARGIN 2

// Almost-empty once used <= margin
`define FIFO_ALMOST_RD_MARGIN 2

`endif
